/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_decode_issue
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := TEST RESULT: PASS

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) test/tb_checks.svh test/issue_input.txt

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	cat $(LOG)

check: run
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/decode_issue_top.sv */
module decode_issue_top import rs_issue_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,

    // instruction queue
    input  logic     instr_valid_i,
    input  xlen_t    instr_i,
    input  xlen_t    pc_i,
    output logic     instr_read_o,

    // register file
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    input  xlen_t    rs1_value_i,
    input  rob_tag_t rs1_tag_i,
    input  xlen_t    rs2_value_i,
    input  rob_tag_t rs2_tag_i,
    output logic     rename_we_o,
    output reg_idx_t rename_rd_o,
    output rob_tag_t rename_tag_o,

    // reorder buffer
    input  rob_tag_t rob_free_tag_i,
    input  logic     rob_rs1_ready_i,
    input  xlen_t    rob_rs1_value_i,
    input  logic     rob_rs2_ready_i,
    input  xlen_t    rob_rs2_value_i,

    // alu reservation station
    input  logic     alu_rs_full_i,
    output logic     alu_valid_o,
    output alu_op_e  alu_op_o,
    output rob_tag_t alu_rob_tag_o,
    output xlen_t    alu_a_value_o,
    output rob_tag_t alu_a_tag_o,
    output logic     alu_a_ready_o,
    output xlen_t    alu_b_value_o,
    output rob_tag_t alu_b_tag_o,
    output logic     alu_b_ready_o
);

    logic     dec_read;
    logic     issue;
    alu_op_e  dec_op;
    reg_idx_t rd;
    logic     a_sel_pc;
    logic     a_zero;
    logic     b_use_imm;
    xlen_t    imm;
    xlen_t    a_value;
    rob_tag_t a_tag;
    logic     a_ready;
    xlen_t    b_value;
    rob_tag_t b_tag;
    logic     b_ready;
    reg_idx_t prev_rd;
    rob_tag_t prev_tag;

    instr_decoder i_decoder (
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .alu_rs_full_i  (alu_rs_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .instr_read_o   (dec_read),
        .issue_o        (issue),
        .alu_op_o       (dec_op),
        .rd_o           (rd),
        .rs1_o          (rs1_idx_o),
        .rs2_o          (rs2_idx_o),
        .a_sel_pc_o     (a_sel_pc),
        .a_zero_o       (a_zero),
        .b_use_imm_o    (b_use_imm),
        .imm_o          (imm)
    );

    operand_resolver i_resolve_rs1 (
        .src_idx_i   (rs1_idx_o),
        .rf_value_i  (rs1_value_i),
        .rf_tag_i    (rs1_tag_i),
        .rob_ready_i (rob_rs1_ready_i),
        .rob_value_i (rob_rs1_value_i),
        .prev_rd_i   (prev_rd),
        .prev_tag_i  (prev_tag),
        .value_o     (a_value),
        .tag_o       (a_tag),
        .ready_o     (a_ready)
    );

    operand_resolver i_resolve_rs2 (
        .src_idx_i   (rs2_idx_o),
        .rf_value_i  (rs2_value_i),
        .rf_tag_i    (rs2_tag_i),
        .rob_ready_i (rob_rs2_ready_i),
        .rob_value_i (rob_rs2_value_i),
        .prev_rd_i   (prev_rd),
        .prev_tag_i  (prev_tag),
        .value_o     (b_value),
        .tag_o       (b_tag),
        .ready_o     (b_ready)
    );

    issue_unit i_issue (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_i        (issue),
        .alu_op_i       (dec_op),
        .rd_i           (rd),
        .rob_free_tag_i (rob_free_tag_i),
        .pc_i           (pc_i),
        .imm_i          (imm),
        .a_sel_pc_i     (a_sel_pc),
        .a_zero_i       (a_zero),
        .b_use_imm_i    (b_use_imm),
        .a_value_i      (a_value),
        .a_tag_i        (a_tag),
        .a_ready_i      (a_ready),
        .b_value_i      (b_value),
        .b_tag_i        (b_tag),
        .b_ready_i      (b_ready),
        .alu_valid_o    (alu_valid_o),
        .alu_op_o       (alu_op_o),
        .alu_rob_tag_o  (alu_rob_tag_o),
        .alu_a_value_o  (alu_a_value_o),
        .alu_a_tag_o    (alu_a_tag_o),
        .alu_a_ready_o  (alu_a_ready_o),
        .alu_b_value_o  (alu_b_value_o),
        .alu_b_tag_o    (alu_b_tag_o),
        .alu_b_ready_o  (alu_b_ready_o),
        .prev_rd_o      (prev_rd),
        .prev_tag_o     (prev_tag)
    );

    // nothing is taken from the queue while reset is held
    assign instr_read_o = dec_read && arst_n_i;

    // rename rd to the free rob tag on every issued instruction
    assign rename_we_o  = issue && arst_n_i;
    assign rename_rd_o  = rd;
    assign rename_tag_o = rob_free_tag_i;

endmodule

/* source/instr_decoder.sv */
module instr_decoder import rs_issue_pkg::*; (
    input  logic     instr_valid_i,
    input  xlen_t    instr_i,
    input  xlen_t    pc_i,
    input  logic     alu_rs_full_i,
    input  rob_tag_t rob_free_tag_i,

    output logic     instr_read_o,
    output logic     issue_o,
    output alu_op_e  alu_op_o,
    output reg_idx_t rd_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output logic     a_sel_pc_o,
    output logic     a_zero_o,
    output logic     b_use_imm_o,
    output xlen_t    imm_o
);

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_form;
    xlen_t      i_imm;
    xlen_t      u_imm;
    logic       supported;
    logic       discard;
    logic       can_issue;

    // field slicing
    assign opcode   = rv_opcode_e'(instr_i[6:0]);
    assign rd_o     = instr_i[11:7];
    assign funct3   = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign funct7   = instr_i[31:25];
    assign alt_form = funct7[FUNCT7_ALT_BIT];

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign u_imm = {instr_i[31:12], 12'h000};

    always_comb begin
        supported = 1'b1;
        alu_op_o  = alu_op_e'({1'b0, funct3});
        case (opcode)
            op_lui, op_auipc: begin
                alu_op_o = alu_add;
            end
            op_imm: begin
                // addi has no sub form, the bit belongs to the immediate
                if (funct3 == FUNCT3_SRL_SRA && alt_form) begin
                    alu_op_o = alu_sra;
                end
            end
            op_reg: begin
                if (funct3 == FUNCT3_ADD_SUB && alt_form) begin
                    alu_op_o = alu_sub;
                end else if (funct3 == FUNCT3_SRL_SRA && alt_form) begin
                    alu_op_o = alu_sra;
                end
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // operand source selection
    assign a_sel_pc_o  = (opcode == op_auipc);
    assign a_zero_o    = (opcode == op_lui);
    assign b_use_imm_o = (opcode != op_reg);
    assign imm_o       = (opcode == op_lui || opcode == op_auipc) ? u_imm : i_imm;

    // rd of x0 and unknown opcodes are dropped without a rob entry
    assign discard   = !supported || (rd_o == '0);
    assign can_issue = !alu_rs_full_i && (rob_free_tag_i != ROB_TAG_NONE);

    assign instr_read_o = instr_valid_i && (discard || can_issue);
    assign issue_o      = instr_valid_i && !discard && can_issue;

    always_comb begin
        // the queue only delivers word aligned fetch addresses
        assert (!(instr_valid_i && a_sel_pc_o) || pc_i[1:0] == 2'b00)
            else $error("auipc with misaligned pc %h", pc_i);
    end

endmodule

/* source/issue_unit.sv */
module issue_unit import rs_issue_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,

    // decoded instruction
    input  logic     issue_i,
    input  alu_op_e  alu_op_i,
    input  reg_idx_t rd_i,
    input  rob_tag_t rob_free_tag_i,
    input  xlen_t    pc_i,
    input  xlen_t    imm_i,
    input  logic     a_sel_pc_i,
    input  logic     a_zero_i,
    input  logic     b_use_imm_i,

    // resolved register operands
    input  xlen_t    a_value_i,
    input  rob_tag_t a_tag_i,
    input  logic     a_ready_i,
    input  xlen_t    b_value_i,
    input  rob_tag_t b_tag_i,
    input  logic     b_ready_i,

    // alu reservation station entry
    output logic     alu_valid_o,
    output alu_op_e  alu_op_o,
    output rob_tag_t alu_rob_tag_o,
    output xlen_t    alu_a_value_o,
    output rob_tag_t alu_a_tag_o,
    output logic     alu_a_ready_o,
    output xlen_t    alu_b_value_o,
    output rob_tag_t alu_b_tag_o,
    output logic     alu_b_ready_o,

    // back-to-back bypass record
    output reg_idx_t prev_rd_o,
    output rob_tag_t prev_tag_o
);

    xlen_t    a_value;
    rob_tag_t a_tag;
    logic     a_ready;
    xlen_t    b_value;
    rob_tag_t b_tag;
    logic     b_ready;

    // operand a: pc for auipc, zero for lui, else rs1
    always_comb begin
        if (a_zero_i) begin
            a_value = '0;
            a_tag   = ROB_TAG_NONE;
            a_ready = 1'b1;
        end else if (a_sel_pc_i) begin
            a_value = pc_i;
            a_tag   = ROB_TAG_NONE;
            a_ready = 1'b1;
        end else begin
            a_value = a_value_i;
            a_tag   = a_tag_i;
            a_ready = a_ready_i;
        end
    end

    // operand b: immediate or rs2
    assign b_value = b_use_imm_i ? imm_i : b_value_i;
    assign b_tag   = b_use_imm_i ? ROB_TAG_NONE : b_tag_i;
    assign b_ready = b_use_imm_i ? 1'b1 : b_ready_i;

    // control state
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_valid_o <= 1'b0;
            prev_rd_o   <= '0;
            prev_tag_o  <= ROB_TAG_NONE;
        end else begin
            alu_valid_o <= issue_i;
            // record only lives for the very next cycle
            prev_rd_o   <= issue_i ? rd_i : '0;
            prev_tag_o  <= issue_i ? rob_free_tag_i : ROB_TAG_NONE;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (issue_i) begin
            alu_op_o      <= alu_op_i;
            alu_rob_tag_o <= rob_free_tag_i;
            alu_a_value_o <= a_value;
            alu_a_tag_o   <= a_tag;
            alu_a_ready_o <= a_ready;
            alu_b_value_o <= b_value;
            alu_b_tag_o   <= b_tag;
            alu_b_ready_o <= b_ready;
        end
    end

    // decoder only issues with a free rob entry
    assert property (@(posedge clk) disable iff (!arst_n_i)
        alu_valid_o |-> alu_rob_tag_o != ROB_TAG_NONE)
        else $error("alu entry issued with rob tag zero");

endmodule

/* source/operand_resolver.sv */
module operand_resolver import rs_issue_pkg::*; (
    input  reg_idx_t src_idx_i,

    // register file read
    input  xlen_t    rf_value_i,
    input  rob_tag_t rf_tag_i,

    // rob entry named by rf_tag_i
    input  logic     rob_ready_i,
    input  xlen_t    rob_value_i,

    // destination of the instruction issued last cycle
    input  reg_idx_t prev_rd_i,
    input  rob_tag_t prev_tag_i,

    output xlen_t    value_o,
    output rob_tag_t tag_o,
    output logic     ready_o
);

    logic bypass_hit;
    logic fwd_hit;

    // the register file has not seen last cycle's rename yet
    assign bypass_hit = (src_idx_i != '0) && (src_idx_i == prev_rd_i);

    // producer already finished, take its result from the rob
    assign fwd_hit = (rf_tag_i != ROB_TAG_NONE) && rob_ready_i;

    always_comb begin
        if (bypass_hit) begin
            value_o = '0;
            tag_o   = prev_tag_i;
            ready_o = 1'b0;
        end else if (fwd_hit) begin
            value_o = rob_value_i;
            tag_o   = ROB_TAG_NONE;
            ready_o = 1'b1;
        end else begin
            value_o = rf_value_i;
            tag_o   = rf_tag_i;
            ready_o = (rf_tag_i == ROB_TAG_NONE);
        end
    end

endmodule

/* source/rs_issue_pkg.sv */
package rs_issue_pkg;

    // data path word
    typedef logic [31:0] xlen_t;

    // architectural register index, x0 .. x31
    typedef logic [4:0] reg_idx_t;

    // reorder buffer tag, zero means no producer
    typedef logic [3:0] rob_tag_t;

    // tag value for "operand ready" and "no free rob entry"
    localparam rob_tag_t ROB_TAG_NONE = 4'd0;

    // funct7 bit that turns add into sub and srl into sra
    localparam int FUNCT7_ALT_BIT = 5;

    // supported major opcodes
    // anything else is consumed by the issue stage without issue
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_e;

    // alu operations
    // low three bits follow funct3 so the common case is a plain cast
    // msb set marks the alternate form selected by funct7
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    // funct3 codes that have an alternate form
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;

endpackage

/* src.f */
+incdir+test
source/rs_issue_pkg.sv
source/instr_decoder.sv
source/operand_resolver.sv
source/issue_unit.sv
source/decode_issue_top.sv
test/tb_decode_issue.sv

/* test/issue_input.txt */
# name instr pc rs1_val rs1_tag rs2_val rs2_tag rob1_rdy rob1_val rob2_rdy rob2_val full free hold gap
# then expected read issue op tag a_val a_tag a_rdy b_val b_tag b_rdy, all numbers in hex
addi_neg FFB10093 00001000 00000064 0 00000000 0 0 00000000 0 00000000 0 1 0 1 1 1 0 1 00000064 0 1 FFFFFFFB 0 1
slti_wait 00722193 00001004 0000000A 5 00000000 0 0 00000000 0 00000000 0 2 0 1 1 1 2 2 0000000A 5 0 00000007 0 1
xori_fwd 0F034293 00001008 DEADBEEF 3 00000000 0 1 12345678 0 00000000 0 3 0 1 1 1 4 3 12345678 0 1 000000F0 0 1
slli 00341393 0000100C 00000011 0 00000000 0 0 00000000 0 00000000 0 4 0 1 1 1 1 4 00000011 0 1 00000003 0 1
srli 00455493 00001010 80000000 0 00000000 0 0 00000000 0 00000000 0 5 0 1 1 1 5 5 80000000 0 1 00000004 0 1
srai 40465593 00001014 F0000000 0 00000000 0 0 00000000 0 00000000 0 6 0 1 1 1 D 6 F0000000 0 1 00000404 0 1
add_rr 00F706B3 00001018 00000001 0 00000002 7 0 00000000 0 00000000 0 7 0 1 1 1 0 7 00000001 0 1 00000002 7 0
sub_fwd 41288833 0000101C 11111111 2 00000005 0 1 AAAA0000 0 00000000 0 8 0 1 1 1 8 8 AAAA0000 0 1 00000005 0 1
sltu_rr 015A39B3 00001020 00000010 0 FFFFFFFF 0 0 00000000 0 00000000 0 9 0 1 1 1 3 9 00000010 0 1 FFFFFFFF 0 1
add_prod 002082B3 00001024 00000003 0 00000004 0 0 00000000 0 00000000 0 A 0 1 1 1 0 A 00000003 0 1 00000004 0 1
xor_b2b_rs1 0032C333 00001028 77777777 0 00000009 0 0 00000000 0 00000000 0 B 0 0 1 1 4 B 00000000 A 0 00000009 0 1
or_b2b_rs2 0060E3B3 0000102C 00000020 0 55555555 0 0 00000000 0 00000000 0 C 0 0 1 1 6 C 00000020 0 1 00000000 B 0
or_after_idle 0060E3B3 0000102C 00000020 0 55555555 0 0 00000000 0 00000000 0 D 0 1 1 1 6 D 00000020 0 1 55555555 0 1
lui 12345437 00001030 00000000 0 00000000 0 0 00000000 0 00000000 0 E 0 1 1 1 0 E 00000000 0 1 12345000 0 1
auipc FFFFF497 00002000 00000000 0 00000000 0 0 00000000 0 00000000 0 F 0 1 1 1 0 F 00002000 0 1 FFFFF000 0 1
stall_full 00208533 00001034 00000100 0 00000200 0 0 00000000 0 00000000 1 3 3 1 0 0 0 0 00000000 0 0 00000000 0 0
stall_notag 00208533 00001034 00000100 0 00000200 0 0 00000000 0 00000000 0 0 4 1 0 0 0 0 00000000 0 0 00000000 0 0
stall_release 00208533 00001034 00000100 0 00000200 0 0 00000000 0 00000000 0 3 0 1 1 1 0 3 00000100 0 1 00000200 0 1
discard_rd0 00108013 00001038 00000000 0 00000000 0 0 00000000 0 00000000 1 0 0 1 1 0 0 0 00000000 0 0 00000000 0 0
discard_store 00112223 0000103C 00000000 0 00000000 0 0 00000000 0 00000000 0 5 0 1 1 0 0 0 00000000 0 0 00000000 0 0

/* test/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compare helpers, included inside tb_decode_issue

task automatic check_word(input string name, input string what, input xlen_t exp_v,
                          input xlen_t act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s %s expected %h actual %h", name, what, exp_v, act_v);
        fail_stop();
    end
endtask

task automatic check_tag(input string name, input string what, input rob_tag_t exp_v,
                         input rob_tag_t act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s %s expected %h actual %h", name, what, exp_v, act_v);
        fail_stop();
    end
endtask

task automatic check_idx(input string name, input string what, input reg_idx_t exp_v,
                         input reg_idx_t act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s %s expected %h actual %h", name, what, exp_v, act_v);
        fail_stop();
    end
endtask

task automatic check_op(input string name, input string what, input alu_op_e exp_v,
                        input alu_op_e act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s %s expected %h actual %h", name, what, exp_v, act_v);
        fail_stop();
    end
endtask

task automatic check_bit(input string name, input string what, input logic exp_v,
                         input logic act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s %s expected %b actual %b", name, what, exp_v, act_v);
        fail_stop();
    end
endtask

`endif

/* test/tb_decode_issue.sv */
module tb_decode_issue import rs_issue_pkg::*; ();

    localparam int CLK_HALF       = 50;
    localparam int RESET_CYCLES   = 5;
    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int SEED           = 32'h2090;

    // addi x1, x0, 1 offered while reset is held
    localparam xlen_t RESET_INSTR = 32'h00100093;

    // column positions in one stimulus line, after the name
    localparam int F_INSTR     = 0;
    localparam int F_PC        = 1;
    localparam int F_RS1_VAL   = 2;
    localparam int F_RS1_TAG   = 3;
    localparam int F_RS2_VAL   = 4;
    localparam int F_RS2_TAG   = 5;
    localparam int F_ROB1_RDY  = 6;
    localparam int F_ROB1_VAL  = 7;
    localparam int F_ROB2_RDY  = 8;
    localparam int F_ROB2_VAL  = 9;
    localparam int F_FULL      = 10;
    localparam int F_FREE      = 11;
    localparam int F_HOLD      = 12;
    localparam int F_GAP       = 13;
    localparam int F_EXP_READ  = 14;
    localparam int F_EXP_ISSUE = 15;
    localparam int F_EXP_OP    = 16;
    localparam int F_EXP_TAG   = 17;
    localparam int F_A_VAL     = 18;
    localparam int F_A_TAG     = 19;
    localparam int F_A_RDY     = 20;
    localparam int F_B_VAL     = 21;
    localparam int F_B_TAG     = 22;
    localparam int F_B_RDY     = 23;

    logic     clk = 1'b0;
    logic     arst_n_i;
    logic     instr_valid_i;
    xlen_t    instr_i;
    xlen_t    pc_i;
    logic     instr_read_o;
    reg_idx_t rs1_idx_o;
    reg_idx_t rs2_idx_o;
    xlen_t    rs1_value_i;
    rob_tag_t rs1_tag_i;
    xlen_t    rs2_value_i;
    rob_tag_t rs2_tag_i;
    logic     rename_we_o;
    reg_idx_t rename_rd_o;
    rob_tag_t rename_tag_o;
    rob_tag_t rob_free_tag_i;
    logic     rob_rs1_ready_i;
    xlen_t    rob_rs1_value_i;
    logic     rob_rs2_ready_i;
    xlen_t    rob_rs2_value_i;
    logic     alu_rs_full_i;
    logic     alu_valid_o;
    alu_op_e  alu_op_o;
    rob_tag_t alu_rob_tag_o;
    xlen_t    alu_a_value_o;
    rob_tag_t alu_a_tag_o;
    logic     alu_a_ready_o;
    xlen_t    alu_b_value_o;
    rob_tag_t alu_b_tag_o;
    logic     alu_b_ready_o;

    logic [31:0] cur [24];
    logic [31:0] prev [24];
    string       cur_name;
    string       prev_name;
    logic        have_prev;

    decode_issue_top i_dut (.*);

    always #CLK_HALF clk = ~clk;

    task automatic fail_stop();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_checks.svh"

    // every cycle is entered at the drive point after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic set_idle();
        instr_valid_i   = 1'b0;
        instr_i         = '0;
        pc_i            = '0;
        rs1_value_i     = '0;
        rs1_tag_i       = ROB_TAG_NONE;
        rs2_value_i     = '0;
        rs2_tag_i       = ROB_TAG_NONE;
        rob_rs1_ready_i = 1'b0;
        rob_rs1_value_i = '0;
        rob_rs2_ready_i = 1'b0;
        rob_rs2_value_i = '0;
        alu_rs_full_i   = 1'b0;
        rob_free_tag_i  = ROB_TAG_NONE;
    endtask

    task automatic drive_step();
        instr_valid_i   = 1'b1;
        instr_i         = cur[F_INSTR];
        pc_i            = cur[F_PC];
        rs1_value_i     = cur[F_RS1_VAL];
        rs1_tag_i       = cur[F_RS1_TAG][3:0];
        rs2_value_i     = cur[F_RS2_VAL];
        rs2_tag_i       = cur[F_RS2_TAG][3:0];
        rob_rs1_ready_i = cur[F_ROB1_RDY][0];
        rob_rs1_value_i = cur[F_ROB1_VAL];
        rob_rs2_ready_i = cur[F_ROB2_RDY][0];
        rob_rs2_value_i = cur[F_ROB2_VAL];
        alu_rs_full_i   = cur[F_FULL][0];
        rob_free_tag_i  = cur[F_FREE][3:0];
    endtask

    // entry of the last issued step, one cycle after its consume edge
    task automatic wait_alu_entry();
        int n;
        n = 0;
        while (!alu_valid_o) begin
            if (n == TIMEOUT_CYCLES) begin
                $display("ERROR: alu_valid_o never went high for step %s", prev_name);
                fail_stop();
            end
            next_cycle();
            #1;
            n++;
        end
        check_op(prev_name, "alu_op_o", alu_op_e'(prev[F_EXP_OP][3:0]), alu_op_o);
        check_tag(prev_name, "alu_rob_tag_o", prev[F_EXP_TAG][3:0], alu_rob_tag_o);
        check_word(prev_name, "alu_a_value_o", prev[F_A_VAL], alu_a_value_o);
        check_tag(prev_name, "alu_a_tag_o", prev[F_A_TAG][3:0], alu_a_tag_o);
        check_bit(prev_name, "alu_a_ready_o", prev[F_A_RDY][0], alu_a_ready_o);
        check_word(prev_name, "alu_b_value_o", prev[F_B_VAL], alu_b_value_o);
        check_tag(prev_name, "alu_b_tag_o", prev[F_B_TAG][3:0], alu_b_tag_o);
        check_bit(prev_name, "alu_b_ready_o", prev[F_B_RDY][0], alu_b_ready_o);
    endtask

    task automatic run_step();
        int n;
        n = 0;
        // register file read addresses are the rs1 and rs2 fields
        check_idx(cur_name, "rs1_idx_o", cur[F_INSTR][19:15], rs1_idx_o);
        check_idx(cur_name, "rs2_idx_o", cur[F_INSTR][24:20], rs2_idx_o);
        if (cur[F_EXP_READ][0]) begin
            while (!instr_read_o) begin
                if (n == TIMEOUT_CYCLES) begin
                    $display("ERROR: instr_read_o never went high in step %s", cur_name);
                    fail_stop();
                end
                next_cycle();
                #1;
                n++;
            end
            check_bit(cur_name, "rename_we_o", cur[F_EXP_ISSUE][0], rename_we_o);
            if (cur[F_EXP_ISSUE][0]) begin
                check_idx(cur_name, "rename_rd_o", cur[F_INSTR][11:7], rename_rd_o);
                check_tag(cur_name, "rename_tag_o", cur[F_FREE][3:0], rename_tag_o);
            end
            next_cycle();
            if (cur[F_EXP_ISSUE][0]) begin
                have_prev = 1'b1;
                prev      = cur;
                prev_name = cur_name;
            end else begin
                // consumed without issue, nothing reaches the station
                set_idle();
                #1;
                check_bit(cur_name, "alu_valid_o", 1'b0, alu_valid_o);
            end
        end else begin
            repeat (cur[F_HOLD]) begin
                check_bit(cur_name, "instr_read_o", 1'b0, instr_read_o);
                check_bit(cur_name, "alu_valid_o", 1'b0, alu_valid_o);
                check_bit(cur_name, "rename_we_o", 1'b0, rename_we_o);
                next_cycle();
                #1;
            end
        end
    endtask

    initial begin
        int    fd;
        int    got;
        int    idles;
        string line;

        void'($urandom(SEED));
        arst_n_i  = 1'b0;
        have_prev = 1'b0;
        set_idle();
        // an issuable instruction waits in the queue during reset
        instr_valid_i  = 1'b1;
        instr_i        = RESET_INSTR;
        rob_free_tag_i = 4'd1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_bit("reset", "alu_valid_o", 1'b0, alu_valid_o);
        check_bit("reset", "instr_read_o", 1'b0, instr_read_o);
        check_bit("reset", "rename_we_o", 1'b0, rename_we_o);
        set_idle();
        arst_n_i = 1'b1;
        next_cycle();
        #1;
        check_bit("after_reset", "alu_valid_o", 1'b0, alu_valid_o);

        fd = $fopen("test/issue_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file");
            fail_stop();
        end

        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            got = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                cur_name, cur[0], cur[1], cur[2], cur[3], cur[4], cur[5], cur[6], cur[7],
                cur[8], cur[9], cur[10], cur[11], cur[12], cur[13], cur[14], cur[15],
                cur[16], cur[17], cur[18], cur[19], cur[20], cur[21], cur[22], cur[23]);
            if (got != 25) begin
                $display("ERROR: malformed line in the stimulus file: %s", line);
                fail_stop();
            end
            if (!have_prev || cur[F_GAP] != 0) begin
                set_idle();
                if (have_prev) begin
                    #1;
                    wait_alu_entry();
                end
                idles = $urandom % 4;
                repeat (idles) next_cycle();
                next_cycle();
                drive_step();
                #1;
            end else begin
                // back to back, the new instruction overlaps the pulse
                drive_step();
                #1;
                wait_alu_entry();
            end
            have_prev = 1'b0;
            run_step();
        end
        $fclose(fd);

        if (have_prev) begin
            set_idle();
            #1;
            wait_alu_entry();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
